/* rtl/mmu_defines.svh */
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

`default_nettype none

// TLB geometry, 16 entries also works
`define TLB_LINE_NUM    32
`define TLB_INDEX_W     $clog2(`TLB_LINE_NUM)

// address split for the 4 KB base page
`define PAGE_OFFSET_W   12
`define PFN_W           (32 - `PAGE_OFFSET_W)
`define VPN2_W          19
`define PAGE_MASK_W     16
`define ASID_W          8

// unmapped segments, kseg0 at 0x8000_0000 and kseg1 at 0xa000_0000
`define KSEG01_TOP      2'b10
`define KSEG1_TOP       3'b101

// cache attribute meaning uncached
`define CACHE_UNCACHED  3'd2

`default_nettype wire

`endif

/* rtl/mmu_pkg.sv */
`include "mmu_defines.svh"

`default_nettype none

package mmu_pkg;

    // EntryLo0/1 layout below bit 26
    typedef struct packed {
        logic [`PFN_W-1:0] pfn;
        logic [2:0]        c;
        logic              d;
        logic              v;
        logic              g;
    } entry_lo_t;

    // one TLB line, lo0 maps the even page and lo1 the odd page
    typedef struct packed {
        logic [`VPN2_W-1:0]      vpn2;
        logic [`ASID_W-1:0]      asid;
        logic                    g;
        logic [`PAGE_MASK_W-1:0] page_mask;
        entry_lo_t               lo0;
        entry_lo_t               lo1;
    } tlb_entry_t;

    // E stage request of one port
    typedef struct packed {
        logic [31:0] vaddr;
        logic        en;
        logic        write;
    } xlate_req_t;

    // M stage answer of one port
    typedef struct packed {
        logic [`PFN_W-1:0] pfn;
        logic              uncached;
        logic              refill;
        logic              invalid;
        logic              modify;
    } xlate_resp_t;

    typedef enum logic [2:0] {
        op_none,
        op_probe,
        op_read,
        op_write_indexed,
        op_write_random
    } tlb_op_t;

    typedef enum logic [2:0] {
        sel_entry_hi,
        sel_page_mask,
        sel_entry_lo0,
        sel_entry_lo1,
        sel_index,
        sel_random
    } cp0_sel_t;

endpackage

`default_nettype wire

/* rtl/tlb_array.sv */
`timescale 1ns/1ps
`include "mmu_defines.svh"

`default_nettype none

module tlb_array
    import mmu_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic [31:0]             lookup_vaddr_i,
    input  wire logic [31:0]             lookup_vaddr_d,
    input  wire logic [`VPN2_W-1:0]      probe_vpn2,
    input  wire logic [`ASID_W-1:0]      asid,
    input  wire logic [`TLB_INDEX_W-1:0] read_index_i,
    input  wire logic [`TLB_INDEX_W-1:0] read_index_d,
    input  wire logic [`TLB_INDEX_W-1:0] read_index_op,
    input  wire logic                    write_en,
    input  wire logic [`TLB_INDEX_W-1:0] write_index,
    input  wire tlb_entry_t              write_entry,
    output logic                         hit_i,
    output logic                         hit_d,
    output logic                         hit_probe,
    output logic [`TLB_INDEX_W-1:0]      hit_index_i,
    output logic [`TLB_INDEX_W-1:0]      hit_index_d,
    output logic [`TLB_INDEX_W-1:0]      hit_index_probe,
    output tlb_entry_t                   entry_i,
    output tlb_entry_t                   entry_d,
    output tlb_entry_t                   entry_op
);

    localparam int LINES   = `TLB_LINE_NUM;
    localparam int INDEX_W = `TLB_INDEX_W;

    tlb_entry_t entries [LINES];

    logic [LINES-1:0] mask_i;
    logic [LINES-1:0] mask_d;
    logic [LINES-1:0] mask_probe;

    // vpn2 under the entry's mask, plus global or asid match
    function automatic logic entry_match(
        input tlb_entry_t          e,
        input logic [`VPN2_W-1:0]  vpn2,
        input logic [`ASID_W-1:0]  cur_asid
    );
        logic [`VPN2_W-1:0] vmask;
        vmask = `VPN2_W'(e.page_mask);
        return ((vpn2 & ~vmask) == e.vpn2) && (e.g || (e.asid == cur_asid));
    endfunction

    // one-hot mask to index
    function automatic logic [INDEX_W-1:0] encode(input logic [LINES-1:0] mask);
        logic [INDEX_W-1:0] idx;
        idx = '0;
        for (int n = 0; n < LINES; n++) begin
            if (mask[n]) begin
                idx = idx | INDEX_W'(n);
            end
        end
        return idx;
    endfunction

    // apply the mask on the way in so lookups compare stored bits directly
    function automatic tlb_entry_t mask_entry(input tlb_entry_t e);
        tlb_entry_t         m;
        logic [`PFN_W-1:0]  pmask;
        pmask      = `PFN_W'(e.page_mask);
        m          = e;
        m.vpn2     = e.vpn2 & ~(`VPN2_W'(e.page_mask));
        m.g        = e.lo0.g & e.lo1.g;
        m.lo0.pfn  = e.lo0.pfn & ~pmask;
        m.lo1.pfn  = e.lo1.pfn & ~pmask;
        return m;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            // each line gets a distinct kseg0 vpn2, never hit by a mapped access
            for (int n = 0; n < LINES; n++) begin
                entries[n]      <= '0;
                entries[n].vpn2 <= {`KSEG01_TOP, (`VPN2_W-2)'(n)};
            end
        end else if (write_en) begin
            entries[write_index] <= mask_entry(write_entry);
        end
    end

    for (genvar n = 0; n < LINES; n++) begin : g_match
        assign mask_i[n] = entry_match(entries[n], lookup_vaddr_i[31 -: `VPN2_W], asid);
        assign mask_d[n] = entry_match(entries[n], lookup_vaddr_d[31 -: `VPN2_W], asid);
        assign mask_probe[n] = entry_match(entries[n], probe_vpn2, asid);
    end

    assign hit_i           = |mask_i;
    assign hit_d           = |mask_d;
    assign hit_probe       = |mask_probe;
    assign hit_index_i     = encode(mask_i);
    assign hit_index_d     = encode(mask_d);
    assign hit_index_probe = encode(mask_probe);

    // index read ports
    assign entry_i  = entries[read_index_i];
    assign entry_d  = entries[read_index_d];
    assign entry_op = entries[read_index_op];

    // two lines covering one page would make the encoder OR their indices
    a_match_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(mask_i) && $onehot0(mask_d) && $onehot0(mask_probe));

    a_write_in_range: assert property (@(posedge clk) disable iff (rst)
        write_en |-> (int'(write_index) < LINES));

endmodule

`default_nettype wire

/* rtl/addr_xlate.sv */
`timescale 1ns/1ps
`include "mmu_defines.svh"

`default_nettype none

module addr_xlate
    import mmu_pkg::*;
#(
    parameter bit CHECK_DIRTY = 1'b1
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    stall,
    input  wire logic                    flush,
    input  wire xlate_req_t              req,
    input  wire logic                    hit,
    input  wire logic [`TLB_INDEX_W-1:0] hit_index,
    input  wire tlb_entry_t              entry,
    output logic [31:0]                  lookup_vaddr,
    output logic [`TLB_INDEX_W-1:0]      read_index,
    output xlate_resp_t                  resp
);

    typedef struct packed {
        logic                    en;
        logic                    write;
        logic                    kseg01;
        logic                    kseg1;
        logic                    hit;
        logic [`TLB_INDEX_W-1:0] index;
        logic [`PFN_W-1:0]       vpn;
    } m_state_t;

    m_state_t m_d;
    m_state_t m_q;

    logic [`PAGE_MASK_W:0] mask_ext;
    logic [`PAGE_MASK_W:0] odd_sel;
    logic                  odd_page;
    entry_lo_t             lo_sel;
    logic                  mapped;

    assign lookup_vaddr = req.vaddr;

    // E stage decode
    always_comb begin
        m_d.en     = req.en;
        m_d.write  = req.write;
        m_d.kseg01 = (req.vaddr[31:30] == `KSEG01_TOP);
        m_d.kseg1  = (req.vaddr[31:29] == `KSEG1_TOP);
        m_d.hit    = hit;
        m_d.index  = hit_index;
        m_d.vpn    = req.vaddr[31 -: `PFN_W];
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            m_q <= '0;
        end else if (!stall) begin
            m_q <= m_d;
        end
    end

    assign read_index = m_q.index;

    // even/odd select sits just above the bits the page mask passes through
    assign mask_ext = {entry.page_mask, 1'b1};
    assign odd_sel  = mask_ext & ~(mask_ext >> 1);
    assign odd_page = |(m_q.vpn[`PAGE_MASK_W:0] & odd_sel);
    assign lo_sel   = odd_page ? entry.lo1 : entry.lo0;
    assign mapped   = m_q.en && !m_q.kseg01;

    always_comb begin
        if (m_q.kseg01) begin
            resp.pfn      = {3'b000, m_q.vpn[`PFN_W-4:0]};
            resp.uncached = m_q.en && m_q.kseg1;
        end else begin
            // low pfn bits come straight from the address for large pages
            resp.pfn      = lo_sel.pfn | (m_q.vpn & `PFN_W'(entry.page_mask));
            resp.uncached = m_q.en && (lo_sel.c == `CACHE_UNCACHED);
        end
        resp.refill  = mapped && !m_q.hit;
        resp.invalid = mapped && m_q.hit && !lo_sel.v;
        resp.modify  = CHECK_DIRTY && mapped && m_q.hit && m_q.write && lo_sel.v && !lo_sel.d;
    end

    a_one_exception: assert property (@(posedge clk) disable iff (rst)
        $onehot0({resp.refill, resp.invalid, resp.modify}));

    // the line read in M is still the one that hit in E
    a_hit_line_kept: assert property (@(posedge clk) disable iff (rst)
        (mapped && m_q.hit) |->
            (entry.vpn2 == (m_q.vpn[`PFN_W-1:1] & ~`VPN2_W'(entry.page_mask))));

endmodule

`default_nettype wire

/* rtl/tlb_cp0_regs.sv */
`timescale 1ns/1ps
`include "mmu_defines.svh"

`default_nettype none

module tlb_cp0_regs
    import mmu_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire tlb_op_t                 tlb_op,
    input  wire logic                    cp0_we,
    input  wire cp0_sel_t                cp0_wsel,
    input  wire logic [31:0]             cp0_wdata,
    input  wire cp0_sel_t                cp0_rsel,
    input  wire logic                    hit_probe,
    input  wire logic [`TLB_INDEX_W-1:0] hit_index_probe,
    input  wire tlb_entry_t              entry_op,
    output logic [31:0]                  cp0_rdata,
    output logic [`ASID_W-1:0]           asid,
    output logic [`VPN2_W-1:0]           probe_vpn2,
    output logic [`TLB_INDEX_W-1:0]      read_index_op,
    output logic                         write_en,
    output logic [`TLB_INDEX_W-1:0]      write_index,
    output tlb_entry_t                   write_entry
);

    localparam int MASK_LSB = `PAGE_OFFSET_W + 1;
    localparam int LO_W     = $bits(entry_lo_t);
    localparam int INDEX_W  = `TLB_INDEX_W;

    logic [`VPN2_W-1:0]      hi_vpn2;
    logic [`ASID_W-1:0]      hi_asid;
    logic [`PAGE_MASK_W-1:0] page_mask_q;
    entry_lo_t               lo0_q;
    entry_lo_t               lo1_q;
    logic                    index_p;
    logic [`TLB_INDEX_W-1:0] index_q;
    logic [`TLB_INDEX_W-1:0] random_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            hi_vpn2     <= '0;
            hi_asid     <= '0;
            page_mask_q <= '0;
            lo0_q       <= '0;
            lo1_q       <= '0;
            index_p     <= 1'b0;
            index_q     <= '0;
            random_q    <= INDEX_W'(`TLB_LINE_NUM - 1);
        end else begin
            random_q <= (random_q == '0) ? INDEX_W'(`TLB_LINE_NUM - 1) : random_q - 1'b1;
            if (cp0_we) begin
                case (cp0_wsel)
                    sel_entry_hi: begin
                        hi_vpn2 <= cp0_wdata[31 -: `VPN2_W];
                        hi_asid <= cp0_wdata[`ASID_W-1:0];
                    end
                    sel_page_mask: page_mask_q <= cp0_wdata[MASK_LSB +: `PAGE_MASK_W];
                    sel_entry_lo0: lo0_q <= cp0_wdata[LO_W-1:0];
                    sel_entry_lo1: lo1_q <= cp0_wdata[LO_W-1:0];
                    sel_index:     index_q <= cp0_wdata[`TLB_INDEX_W-1:0];
                    default: ;
                endcase
            end else if (tlb_op == op_probe) begin
                index_p <= !hit_probe;
                index_q <= hit_probe ? hit_index_probe : '0;
            end else if (tlb_op == op_read) begin
                hi_vpn2     <= entry_op.vpn2;
                hi_asid     <= entry_op.asid;
                page_mask_q <= entry_op.page_mask;
                // the line keeps one g, both EntryLo get it back
                lo0_q       <= {entry_op.lo0[LO_W-1:1], entry_op.g};
                lo1_q       <= {entry_op.lo1[LO_W-1:1], entry_op.g};
            end
        end
    end

    assign asid          = hi_asid;
    assign probe_vpn2    = hi_vpn2;
    assign read_index_op = index_q;

    assign write_en    = (tlb_op == op_write_indexed) || (tlb_op == op_write_random);
    assign write_index = (tlb_op == op_write_random) ? random_q : index_q;
    assign write_entry = '{vpn2: hi_vpn2, asid: hi_asid, g: lo0_q.g & lo1_q.g,
                           page_mask: page_mask_q, lo0: lo0_q, lo1: lo1_q};

    always_comb begin
        cp0_rdata = '0;
        case (cp0_rsel)
            sel_entry_hi: begin
                cp0_rdata[31 -: `VPN2_W]   = hi_vpn2;
                cp0_rdata[`ASID_W-1:0]     = hi_asid;
            end
            sel_page_mask: cp0_rdata[MASK_LSB +: `PAGE_MASK_W] = page_mask_q;
            sel_entry_lo0: cp0_rdata[LO_W-1:0] = lo0_q;
            sel_entry_lo1: cp0_rdata[LO_W-1:0] = lo1_q;
            sel_index: begin
                cp0_rdata[31]                 = index_p;
                cp0_rdata[`TLB_INDEX_W-1:0]   = index_q;
            end
            sel_random: cp0_rdata[`TLB_INDEX_W-1:0] = random_q;
            default: ;
        endcase
    end

    // software moves and TLB ops come from different instructions
    a_op_xor_move: assert property (@(posedge clk) disable iff (rst)
        !(cp0_we && (tlb_op != op_none)));

endmodule

`default_nettype wire

/* rtl/mmu_top.sv */
`timescale 1ns/1ps
`include "mmu_defines.svh"

`default_nettype none

module mmu_top
    import mmu_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        stall,
    input  wire logic        flush,
    input  wire xlate_req_t  inst_req,
    input  wire xlate_req_t  data_req,
    input  wire tlb_op_t     tlb_op,
    input  wire logic        cp0_we,
    input  wire cp0_sel_t    cp0_wsel,
    input  wire logic [31:0] cp0_wdata,
    input  wire cp0_sel_t    cp0_rsel,
    output xlate_resp_t      inst_resp,
    output xlate_resp_t      data_resp,
    output logic [31:0]      cp0_rdata
);

    xlate_req_t              inst_req_rd;
    logic [31:0]             lookup_vaddr_i;
    logic [31:0]             lookup_vaddr_d;
    logic                    hit_i;
    logic                    hit_d;
    logic                    hit_probe;
    logic [`TLB_INDEX_W-1:0] hit_index_i;
    logic [`TLB_INDEX_W-1:0] hit_index_d;
    logic [`TLB_INDEX_W-1:0] hit_index_probe;
    logic [`TLB_INDEX_W-1:0] read_index_i;
    logic [`TLB_INDEX_W-1:0] read_index_d;
    logic [`TLB_INDEX_W-1:0] read_index_op;
    tlb_entry_t              entry_i;
    tlb_entry_t              entry_d;
    tlb_entry_t              entry_op;
    logic [`ASID_W-1:0]      asid;
    logic [`VPN2_W-1:0]      probe_vpn2;
    logic                    write_en;
    logic [`TLB_INDEX_W-1:0] write_index;
    tlb_entry_t              write_entry;

    // fetches never write
    assign inst_req_rd = '{vaddr: inst_req.vaddr, en: inst_req.en, write: 1'b0};

    addr_xlate #(.CHECK_DIRTY(1'b0)) u_inst_xlate (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush),
        .req(inst_req_rd), .hit(hit_i), .hit_index(hit_index_i), .entry(entry_i),
        .lookup_vaddr(lookup_vaddr_i), .read_index(read_index_i), .resp(inst_resp)
    );

    addr_xlate #(.CHECK_DIRTY(1'b1)) u_data_xlate (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush),
        .req(data_req), .hit(hit_d), .hit_index(hit_index_d), .entry(entry_d),
        .lookup_vaddr(lookup_vaddr_d), .read_index(read_index_d), .resp(data_resp)
    );

    tlb_array u_tlb_array (
        .clk(clk), .rst(rst),
        .lookup_vaddr_i(lookup_vaddr_i), .lookup_vaddr_d(lookup_vaddr_d),
        .probe_vpn2(probe_vpn2), .asid(asid),
        .read_index_i(read_index_i), .read_index_d(read_index_d),
        .read_index_op(read_index_op),
        .write_en(write_en), .write_index(write_index), .write_entry(write_entry),
        .hit_i(hit_i), .hit_d(hit_d), .hit_probe(hit_probe),
        .hit_index_i(hit_index_i), .hit_index_d(hit_index_d),
        .hit_index_probe(hit_index_probe),
        .entry_i(entry_i), .entry_d(entry_d), .entry_op(entry_op)
    );

    tlb_cp0_regs u_tlb_cp0_regs (
        .clk(clk), .rst(rst), .tlb_op(tlb_op),
        .cp0_we(cp0_we), .cp0_wsel(cp0_wsel), .cp0_wdata(cp0_wdata),
        .cp0_rsel(cp0_rsel), .hit_probe(hit_probe), .hit_index_probe(hit_index_probe),
        .entry_op(entry_op), .cp0_rdata(cp0_rdata), .asid(asid),
        .probe_vpn2(probe_vpn2), .read_index_op(read_index_op),
        .write_en(write_en), .write_index(write_index), .write_entry(write_entry)
    );

endmodule

`default_nettype wire

/* tests/mmu_tb_cases.svh */
task automatic build_table();
    xlate_resp_t a_even;
    xlate_resp_t a_odd;
    xlate_resp_t refill0;
    int          wr_step;
    a_even  = make_resp(20'h12345, 1'b0, 1'b0, 1'b0, 1'b0);
    a_odd   = make_resp(20'h0abcd, 1'b1, 1'b0, 1'b0, 1'b0);
    refill0 = make_resp(20'h0, 1'b0, 1'b1, 1'b0, 1'b0);

    begin_group("unmapped");
    translate(32'h8000_1234, 32'ha012_3456, 1'b0,
              unmapped_resp(32'h8000_1234), unmapped_resp(32'ha012_3456));
    translate(32'hbfc0_0000, 32'h8040_0000, 1'b1,
              unmapped_resp(32'hbfc0_0000), unmapped_resp(32'h8040_0000));

    // entry A at index 5, 4 KB pages, asid 12, lo1 uncached and clean
    begin_group("tlbwi");
    move_to_cp0(sel_entry_hi, 32'h0040_0012);
    move_to_cp0(sel_entry_lo0, 32'h0048_d15e);
    move_to_cp0(sel_entry_lo1, 32'h002a_f352);
    move_to_cp0(sel_index, 32'd5);
    tlb_cmd(op_write_indexed);
    translate(32'h0040_0123, 32'h0040_0ffc, 1'b0, a_even, a_even);
    translate(32'h0040_1000, 32'h0040_1456, 1'b0, a_odd, a_odd);

    begin_group("modify");
    translate(32'h0040_1000, 32'h0040_1456, 1'b1, a_odd,
              make_resp(20'h0abcd, 1'b1, 1'b0, 1'b0, 1'b1));
    translate(32'h0040_0123, 32'h0040_0123, 1'b1, a_even, a_even);

    // entry B at index 6, 16 KB pages, global, lo0 invalid
    begin_group("invalid");
    move_to_cp0(sel_page_mask, 32'h0000_6000);
    move_to_cp0(sel_entry_hi, 32'h0060_6012);
    move_to_cp0(sel_entry_lo0, 32'h0001_de5d);
    move_to_cp0(sel_entry_lo1, 32'h0002_221f);
    move_to_cp0(sel_index, 32'd6);
    tlb_cmd(op_write_indexed);
    translate(32'h0060_2000, 32'h0060_5000, 1'b0,
              make_resp(20'h0077a, 1'b0, 1'b0, 1'b1, 1'b0),
              make_resp(20'h00889, 1'b0, 1'b0, 1'b0, 1'b0));

    begin_group("refill");
    translate(32'h0050_0000, 32'h0040_0123, 1'b0, refill0, a_even);
    move_to_cp0(sel_entry_hi, 32'h0000_0034);
    translate(32'h0040_0123, 32'h0060_5000, 1'b0, refill0,
              make_resp(20'h00889, 1'b0, 1'b0, 1'b0, 1'b0));

    begin_group("stall_flush");
    translate(32'h8000_1000, 32'h0050_0000, 1'b0, unmapped_resp(32'h8000_1000), refill0);
    translate(32'ha000_2000, 32'h8000_3000, 1'b0, unmapped_resp(32'h8000_1000), refill0,
              1'b1);
    translate(32'ha000_2000, 32'h8000_3000, 1'b0, unmapped_resp(32'h8000_1000), refill0,
              1'b1);
    translate(32'ha000_2000, 32'h8000_3000, 1'b0,
              unmapped_resp(32'ha000_2000), unmapped_resp(32'h8000_3000));
    translate(32'h0050_0000, 32'h0050_0000, 1'b0, refill0, refill0);
    translate(32'h0050_0000, 32'h0050_0000, 1'b0, '0, '0, 1'b0, 1'b1);
    tlb_cmd(op_none);

    begin_group("probe_read");
    move_to_cp0(sel_entry_hi, 32'h0040_0012);
    tlb_cmd(op_probe);
    read_cp0(sel_index, 32'd5);
    move_to_cp0(sel_entry_hi, 32'h0070_0012);
    tlb_cmd(op_probe);
    read_cp0(sel_index, 32'h8000_0000);
    move_to_cp0(sel_index, 32'd6);
    tlb_cmd(op_read);
    read_cp0(sel_entry_hi, 32'h0060_0012);
    read_cp0(sel_page_mask, 32'h0000_6000);
    read_cp0(sel_entry_lo0, 32'h0001_de1d);
    read_cp0(sel_entry_lo1, 32'h0002_221f);

    // entry C lands wherever Random points
    begin_group("tlbwr");
    move_to_cp0(sel_page_mask, 32'h0);
    move_to_cp0(sel_entry_hi, 32'h0080_0012);
    move_to_cp0(sel_entry_lo0, 32'h0000_401e);
    move_to_cp0(sel_entry_lo1, 32'h0000_401e);
    wr_step = steps.size();
    tlb_cmd(op_write_random);
    tlb_cmd(op_probe);
    read_cp0(sel_index, random_at_step(wr_step));
    read_cp0(sel_random, random_at_step(steps.size()));
    translate(32'h0080_0000, 32'h0080_1000, 1'b0,
              make_resp(20'h00100, 1'b0, 1'b0, 1'b0, 1'b0),
              make_resp(20'h00100, 1'b0, 1'b0, 1'b0, 1'b0));
    tlb_cmd(op_none);
endtask

/* tests/mmu_tb.sv */
`timescale 1ns/1ps
`include "mmu_defines.svh"

`default_nettype none

module mmu_tb
    import mmu_pkg::*;
;

    typedef struct {
        string       group;
        logic        stall;
        logic        flush;
        xlate_req_t  ireq;
        xlate_req_t  dreq;
        tlb_op_t     op;
        logic        we;
        cp0_sel_t    wsel;
        logic [31:0] wdata;
        cp0_sel_t    rsel;
        bit          chk_resp;
        xlate_resp_t exp_i;
        xlate_resp_t exp_d;
        bit          chk_rd;
        logic [31:0] exp_rd;
        logic [31:0] rd_mask;
    } step_t;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        flush;
    xlate_req_t  inst_req;
    xlate_req_t  data_req;
    tlb_op_t     tlb_op;
    logic        cp0_we;
    cp0_sel_t    cp0_wsel;
    logic [31:0] cp0_wdata;
    cp0_sel_t    cp0_rsel;
    xlate_resp_t inst_resp;
    xlate_resp_t data_resp;
    logic [31:0] cp0_rdata;

    step_t steps[$];
    string cur_group;
    int    pass_count;
    int    fail_count;
    int    group_fails;
    int    cycles;
    int    cycle_limit;

    mmu_top dut (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush),
        .inst_req(inst_req), .data_req(data_req), .tlb_op(tlb_op),
        .cp0_we(cp0_we), .cp0_wsel(cp0_wsel), .cp0_wdata(cp0_wdata),
        .cp0_rsel(cp0_rsel), .inst_resp(inst_resp), .data_resp(data_resp),
        .cp0_rdata(cp0_rdata)
    );

    always #10 clk = ~clk;

    function automatic xlate_resp_t make_resp(input logic [`PFN_W-1:0] pfn,
                                              input logic unc, input logic refill,
                                              input logic invalid, input logic modify);
        xlate_resp_t r;
        r = '{pfn: pfn, uncached: unc, refill: refill, invalid: invalid, modify: modify};
        return r;
    endfunction

    // kseg0/kseg1 drop the top three bits, kseg1 is uncached
    function automatic xlate_resp_t unmapped_resp(input logic [31:0] vaddr);
        return make_resp({3'b000, vaddr[28:12]}, vaddr[31:29] == 3'b101, 1'b0, 1'b0, 1'b0);
    endfunction

    // Random as seen by a read in a given step
    // it starts at the top after reset and drops once per clock from step 0's edge
    function automatic logic [31:0] random_at_step(input int step);
        int n;
        n = `TLB_LINE_NUM;
        return 32'(((n - 1 - (step + 1)) % n + n) % n);
    endfunction

    function automatic step_t blank_step();
        step_t s;
        s.group    = cur_group;
        s.stall    = 1'b0;
        s.flush    = 1'b0;
        s.ireq     = '0;
        s.dreq     = '0;
        s.op       = op_none;
        s.we       = 1'b0;
        s.wsel     = sel_entry_hi;
        s.wdata    = '0;
        s.rsel     = sel_entry_hi;
        s.chk_resp = 1'b0;
        s.exp_i    = '0;
        s.exp_d    = '0;
        s.chk_rd   = 1'b0;
        s.exp_rd   = '0;
        s.rd_mask  = 32'hffff_ffff;
        return s;
    endfunction

    task automatic move_to_cp0(input cp0_sel_t sel, input logic [31:0] data);
        step_t s;
        s = blank_step();
        s.we = 1'b1;
        s.wsel = sel;
        s.wdata = data;
        steps.push_back(s);
    endtask

    task automatic tlb_cmd(input tlb_op_t op);
        step_t s;
        s = blank_step();
        s.op = op;
        steps.push_back(s);
    endtask

    // expected values are for the M response in the following cycle
    task automatic translate(input logic [31:0] iaddr, input logic [31:0] daddr,
                             input logic dwrite, input xlate_resp_t ei,
                             input xlate_resp_t ed, input logic hold = 1'b0,
                             input logic kill = 1'b0);
        step_t s;
        s = blank_step();
        // same write bit on the fetch, which must never raise modify
        s.ireq = '{vaddr: iaddr, en: 1'b1, write: dwrite};
        s.dreq = '{vaddr: daddr, en: 1'b1, write: dwrite};
        s.stall = hold;
        s.flush = kill;
        s.chk_resp = 1'b1;
        s.exp_i = ei;
        s.exp_d = ed;
        steps.push_back(s);
    endtask

    task automatic read_cp0(input cp0_sel_t sel, input logic [31:0] exp,
                            input logic [31:0] mask = 32'hffff_ffff);
        step_t s;
        s = blank_step();
        s.rsel = sel;
        s.chk_rd = 1'b1;
        s.exp_rd = exp;
        s.rd_mask = mask;
        steps.push_back(s);
    endtask

    task automatic begin_group(input string name);
        cur_group = name;
    endtask

    `include "mmu_tb_cases.svh"

    task automatic drive_step(input step_t s);
        stall     <= s.stall;
        flush     <= s.flush;
        inst_req  <= s.ireq;
        data_req  <= s.dreq;
        tlb_op    <= s.op;
        cp0_we    <= s.we;
        cp0_wsel  <= s.wsel;
        cp0_wdata <= s.wdata;
        cp0_rsel  <= s.rsel;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            fail_count++;
            group_fails++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_group(input string name);
        $display("group %s: %0d failed checks", name, group_fails);
        group_fails = 0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: run exceeded %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        inst_req = '0;
        data_req = '0;
        tlb_op = op_none;
        cp0_we = 1'b0;
        cp0_wsel = sel_entry_hi;
        cp0_wdata = '0;
        cp0_rsel = sel_entry_hi;
        pass_count = 0;
        fail_count = 0;
        group_fails = 0;
        cycles = 0;
        cycle_limit = 0;
        build_table();
        cycle_limit = steps.size() * 4 + 8;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk);
            drive_step(steps[i]);
            @(negedge clk);
            if (i > 0 && steps[i-1].chk_resp) begin
                check_value("inst_resp", 32'(steps[i-1].exp_i), 32'(inst_resp));
                check_value("data_resp", 32'(steps[i-1].exp_d), 32'(data_resp));
            end
            if (i > 0 && steps[i].group != steps[i-1].group) begin
                report_group(steps[i-1].group);
            end
            if (steps[i].chk_rd) begin
                check_value("cp0_rdata", steps[i].exp_rd & steps[i].rd_mask,
                            cp0_rdata & steps[i].rd_mask);
            end
        end
        report_group(steps[steps.size()-1].group);
        $display("checks passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+rtl
+incdir+tests
rtl/mmu_pkg.sv
rtl/tlb_array.sv
rtl/addr_xlate.sv
rtl/tlb_cp0_regs.sv
rtl/mmu_top.sv
tests/mmu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module mmu_tb -o mmu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/mmu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
